// ==== design/dual_dispatcher.sv ====
`timescale 1ns/1ps
`include "dual_issue_defs.svh"

module dual_dispatcher (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    backend_ready,
    input  logic [1:0]              head_count,
    input  dual_issue_pkg::instr_t  head0,
    input  dual_issue_pkg::instr_t  head1,
    output logic [1:0]              pop_count,
    output logic                    issue_full_valid,
    output logic                    issue_simple_valid,
    output dual_issue_pkg::instr_t  issue_full,
    output dual_issue_pkg::instr_t  issue_simple
);
    import dual_issue_pkg::*;

    // destinations of multi-cycle ops issued last cycle
    logic                   mc_flag0;
    logic                   mc_flag1;
    logic [`REG_ADDR_W-1:0] mc_rd0;
    logic [`REG_ADDR_W-1:0] mc_rd1;

    logic hold0;
    logic hold1;
    logic pair_dep;
    logic younger_ok;
    logic full_valid;
    logic simple_valid;

    // classes the simple pipe can execute
    function automatic logic simple_pipe_ok(input iclass_e c);
        case (c)
            ICLASS_ALU,
            ICLASS_BRANCH,
            ICLASS_MUL,
            ICLASS_ALU_BRANCH,
            ICLASS_BARRIER,
            ICLASS_CNT_READ: simple_pipe_ok = 1'b1;
            default:         simple_pipe_ok = 1'b0;
        endcase
    endfunction

    // result not ready for the next cycle's consumer
    function automatic logic writes_late(input instr_t ins);
        logic slow;
        slow = (ins.iclass == ICLASS_MUL) || (ins.iclass == ICLASS_MEM) ||
               (ins.iclass == ICLASS_DIV) || (ins.iclass == ICLASS_PRIV);
        return slow && ins.reg_write && (ins.rd != '0);
    endfunction

    // source match, rd counts only for stores and branches
    function automatic logic reads_reg(input instr_t ins,
                                       input logic [`REG_ADDR_W-1:0] r);
        return (ins.rj == r) || (ins.rk == r) || (ins.reads_rd && (ins.rd == r));
    endfunction

    // load-use holds against both pipes of the previous cycle
    assign hold0 = (mc_flag0 && reads_reg(head0, mc_rd0)) ||
                   (mc_flag1 && reads_reg(head0, mc_rd1));
    assign hold1 = (mc_flag0 && reads_reg(head1, mc_rd0)) ||
                   (mc_flag1 && reads_reg(head1, mc_rd1));

    // younger reads what the older writes
    assign pair_dep = head0.reg_write && (head0.rd != '0) && reads_reg(head1, head0.rd);

    assign younger_ok = simple_pipe_ok(head1.iclass) && !hold1 && !pair_dep;

    // oldest always goes to the full pipe
    assign full_valid   = backend_ready && (head_count != 2'd0) && !hold0;
    assign simple_valid = full_valid && (head_count == 2'd2) && younger_ok;

    always_comb begin
        issue_full_valid   = full_valid;
        issue_simple_valid = simple_valid;
        issue_full         = full_valid ? head0 : '0;
        issue_simple       = simple_valid ? head1 : '0;
        if (simple_valid) begin
            pop_count = 2'd2;
        end else if (full_valid) begin
            pop_count = 2'd1;
        end else begin
            pop_count = 2'd0;
        end
    end

    // flags only for instructions that really left
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            mc_flag0 <= 1'b0;
            mc_flag1 <= 1'b0;
        end else if (backend_ready) begin
            mc_flag0 <= full_valid && writes_late(head0);
            mc_flag1 <= simple_valid && writes_late(head1);
        end
    end

    always_ff @(posedge clk) begin
        if (backend_ready) begin
            mc_rd0 <= head0.rd;
            mc_rd1 <= head1.rd;
        end
    end

endmodule

// ==== design/dual_issue_defs.svh ====
`ifndef DUAL_ISSUE_DEFS_SVH
`define DUAL_ISSUE_DEFS_SVH

// data and pc width
`define XLEN 32

// architectural register index width, r0 reads as zero
`define REG_ADDR_W 5

// instruction buffer entries between decode and dispatch
`define ISSUE_BUF_DEPTH 4

`endif

// ==== design/dual_issue_pkg.sv ====
`include "dual_issue_defs.svh"

package dual_issue_pkg;

    // execution class of a decoded instruction
    // encoding follows the decoder's control field
    typedef enum logic [3:0] {
        ICLASS_ALU        = 4'd0,
        ICLASS_BRANCH     = 4'd1,
        ICLASS_DIV        = 4'd2,
        ICLASS_PRIV       = 4'd3,
        ICLASS_MUL        = 4'd4,
        ICLASS_MEM        = 4'd5,
        ICLASS_PRIV_MEM   = 4'd6,
        ICLASS_CNT_READ   = 4'd7,
        ICLASS_ALU_BRANCH = 4'd8,
        ICLASS_BARRIER    = 4'd9,
        ICLASS_PRIV_MMU   = 4'd10,
        ICLASS_MMU        = 4'd11
    } iclass_e;

    // one decoded instruction as seen by dispatch
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rk;
        // stores and branches use rd as a source
        logic                   reads_rd;
        logic                   reg_write;
        iclass_e                iclass;
    } instr_t;

    // pair from decode, index 0 is the older slot
    // valid[1] only set together with valid[0]
    typedef struct packed {
        instr_t [1:0] instr;
        logic   [1:0] valid;
    } in_pair_t;

endpackage

// ==== design/issue_stage_top.sv ====
`timescale 1ns/1ps

module issue_stage_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  dual_issue_pkg::in_pair_t  in_pair,
    output logic                      in_ready,
    input  logic                      backend_ready,
    output logic                      issue_full_valid,
    output dual_issue_pkg::instr_t    issue_full,
    output logic                      issue_simple_valid,
    output dual_issue_pkg::instr_t    issue_simple
);
    import dual_issue_pkg::*;

    // buffer head towards the dispatcher
    logic [1:0] head_count;
    logic [1:0] pop_count;
    instr_t     head0;
    instr_t     head1;

    pair_buffer i_pair_buffer (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pair    (in_pair),
        .in_ready   (in_ready),
        .pop_count  (pop_count),
        .head_count (head_count),
        .head0      (head0),
        .head1      (head1)
    );

    dual_dispatcher i_dual_dispatcher (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .backend_ready      (backend_ready),
        .head_count         (head_count),
        .head0              (head0),
        .head1              (head1),
        .pop_count          (pop_count),
        .issue_full_valid   (issue_full_valid),
        .issue_simple_valid (issue_simple_valid),
        .issue_full         (issue_full),
        .issue_simple       (issue_simple)
    );

endmodule

// ==== design/pair_buffer.sv ====
`timescale 1ns/1ps
`include "dual_issue_defs.svh"

module pair_buffer #(
    parameter int DEPTH = `ISSUE_BUF_DEPTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  dual_issue_pkg::in_pair_t  in_pair,
    output logic                      in_ready,
    input  logic [1:0]                pop_count,
    output logic [1:0]                head_count,
    output dual_issue_pkg::instr_t    head0,
    output dual_issue_pkg::instr_t    head1
);
    import dual_issue_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    instr_t           mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic             push;
    logic [1:0]       push_n;
    logic [1:0]       pop_n;

    // circular pointer advance, at most two steps
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input logic [1:0] inc);
        logic [PTR_W:0] sum;
        sum = (PTR_W + 1)'(ptr) + (PTR_W + 1)'(inc);
        if (sum >= DEPTH) begin
            sum = sum - (PTR_W + 1)'(DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    // room for a full pair is required before accepting
    assign in_ready = (count <= CNT_W'(DEPTH - 2));

    // flush wins over a push in the same cycle
    assign push = in_valid && in_ready && !flush;

    always_comb begin
        push_n = 2'd0;
        if (push) begin
            push_n = {1'b0, in_pair.valid[0]} + {1'b0, in_pair.valid[1]};
        end
    end

    // visible head entries, capped at two
    always_comb begin
        if (count >= CNT_W'(2)) begin
            head_count = 2'd2;
        end else begin
            head_count = count[1:0];
        end
    end

    // never release more than the head holds
    assign pop_n = (pop_count > head_count) ? head_count : pop_count;

    // unoccupied head slots read as zero
    assign head0 = (count != '0) ? mem[rd_ptr] : '0;
    assign head1 = (count >= CNT_W'(2)) ? mem[ptr_add(rd_ptr, 2'd1)] : '0;

    // payload storage
    always_ff @(posedge clk) begin
        if (push && in_pair.valid[0]) begin
            mem[wr_ptr] <= in_pair.instr[0];
        end
        // younger slot lands right after the older one
        if (push && in_pair.valid[1]) begin
            mem[ptr_add(wr_ptr, {1'b0, in_pair.valid[0]})] <= in_pair.instr[1];
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, push_n);
            rd_ptr <= ptr_add(rd_ptr, pop_n);
            count  <= count + CNT_W'(push_n) - CNT_W'(pop_n);
        end
    end

endmodule

// ==== dual_issue.f ====
+incdir+design
design/dual_issue_pkg.sv
design/pair_buffer.sv
design/dual_dispatcher.sv
design/issue_stage_top.sv
test/issue_stage_checker.sv
test/tb_issue_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_issue_stage \
    -f dual_issue.f \
    -o tb_issue_stage_sim \
    && ./obj_dir/tb_issue_stage_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/issue_stage_checker.sv ====
`timescale 1ns/1ps

module issue_stage_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   backend_ready,
    input logic                   issue_full_valid,
    input logic                   issue_simple_valid,
    input dual_issue_pkg::instr_t issue_full,
    input dual_issue_pkg::instr_t issue_simple
);
    logic simple_reads_full;

    // younger source matches the older nonzero destination
    assign simple_reads_full = issue_full.reg_write && (issue_full.rd != '0) &&
        ((issue_simple.rj == issue_full.rd) || (issue_simple.rk == issue_full.rd) ||
         (issue_simple.reads_rd && (issue_simple.rd == issue_full.rd)));

    simple_needs_full: assert property (@(posedge clk) disable iff (reset)
        issue_simple_valid |-> issue_full_valid)
        else $error("simple pipe issued without the full pipe");

    stall_blocks_issue: assert property (@(posedge clk) disable iff (reset)
        !backend_ready |-> (!issue_full_valid && !issue_simple_valid))
        else $error("issue while the backend was not ready");

    no_pair_dependence: assert property (@(posedge clk) disable iff (reset)
        issue_simple_valid |-> !simple_reads_full)
        else $error("simple pipe instruction reads the full pipe destination");

    // buffer is empty one edge after reset
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!issue_full_valid && !issue_simple_valid))
        else $error("issue valid high right after reset");

endmodule

bind dual_dispatcher issue_stage_checker i_issue_stage_checker (
    .clk                (clk),
    .reset              (reset),
    .backend_ready      (backend_ready),
    .issue_full_valid   (issue_full_valid),
    .issue_simple_valid (issue_simple_valid),
    .issue_full         (issue_full),
    .issue_simple       (issue_simple)
);

// ==== test/tb_issue_stage.sv ====
`timescale 1ns/1ps
`include "dual_issue_defs.svh"

module tb_issue_stage;
    import dual_issue_pkg::*;

    localparam int N_MIXED   = 12;
    localparam int NUM_PAIRS = 11 + N_MIXED;

    logic     clk;
    logic     reset;
    logic     flush;
    logic     in_valid;
    in_pair_t in_pair;
    logic     in_ready;
    logic     backend_ready;
    logic     issue_full_valid;
    instr_t   issue_full;
    logic     issue_simple_valid;
    instr_t   issue_simple;

    // reference model queue and last cycle's slow destinations
    instr_t                 ref_q[$];
    logic                   lu_valid[2];
    logic [`REG_ADDR_W-1:0] lu_rd[2];
    int                     errors;
    int                     checks;
    logic [31:0]            lcg_state;
    int                     next_pc;

    issue_stage_top i_issue_stage_top (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .in_valid           (in_valid),
        .in_pair            (in_pair),
        .in_ready           (in_ready),
        .backend_ready      (backend_ready),
        .issue_full_valid   (issue_full_valid),
        .issue_full         (issue_full),
        .issue_simple_valid (issue_simple_valid),
        .issue_simple       (issue_simple)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instr_t make_instr(input iclass_e cls, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk,
                                          input logic wr, input logic rrd);
        instr_t ins;
        ins.pc        = 32'h1c00_0000 + 32'(next_pc);
        ins.imm       = ~ins.pc;
        ins.rd        = rd;
        ins.rj        = rj;
        ins.rk        = rk;
        ins.reads_rd  = rrd;
        ins.reg_write = wr;
        ins.iclass    = cls;
        next_pc       = next_pc + 4;
        return ins;
    endfunction

    // registers 0..7 only so that dependences come up often
    function automatic instr_t random_instr();
        logic [31:0] r;
        r = lcg_next();
        return make_instr(iclass_e'(4'(r[27:24] % 4'd12)), {2'b00, r[10:8]},
                          {2'b00, r[14:12]}, {2'b00, r[18:16]}, r[20], r[21]);
    endfunction

    function automatic logic uses_reg(input instr_t ins, input logic [4:0] r);
        return (r != 5'd0) && (ins.rj == r || ins.rk == r || (ins.reads_rd && ins.rd == r));
    endfunction

    function automatic logic held(input instr_t ins);
        return (lu_valid[0] && uses_reg(ins, lu_rd[0])) ||
               (lu_valid[1] && uses_reg(ins, lu_rd[1]));
    endfunction

    function automatic logic slow_result(input instr_t ins);
        return (ins.iclass inside {ICLASS_MUL, ICLASS_MEM, ICLASS_DIV, ICLASS_PRIV}) &&
               ins.reg_write && (ins.rd != 5'd0);
    endfunction

    task automatic compare_port(input string pipe, input logic got_v, input instr_t got,
                                input logic exp_v, input instr_t exp);
        checks++;
        if (got_v !== exp_v || got !== exp) begin
            errors++;
            $display("FAIL %0t: %s pipe gave valid %b %h, expected valid %b %h",
                     $time, pipe, got_v, got, exp_v, exp);
        end
    endtask

    // one clock with DUT outputs compared against the model at the rising edge
    task automatic cycle();
        instr_t exp_full;
        instr_t exp_simple;
        logic   exp_fv;
        logic   exp_sv;
        logic   accept;
        exp_full   = '0;
        exp_simple = '0;
        exp_fv     = 1'b0;
        exp_sv     = 1'b0;
        @(posedge clk);
        accept = in_valid && (ref_q.size() <= `ISSUE_BUF_DEPTH - 2) && !flush;
        if (backend_ready && ref_q.size() > 0 && !held(ref_q[0])) begin
            exp_fv   = 1'b1;
            exp_full = ref_q[0];
        end
        if (exp_fv && ref_q.size() > 1 && !held(ref_q[1]) &&
            (ref_q[1].iclass inside {ICLASS_ALU, ICLASS_BRANCH, ICLASS_MUL,
                                     ICLASS_ALU_BRANCH, ICLASS_BARRIER, ICLASS_CNT_READ}) &&
            !(ref_q[0].reg_write && uses_reg(ref_q[1], ref_q[0].rd))) begin
            exp_sv     = 1'b1;
            exp_simple = ref_q[1];
        end
        compare_port("full", issue_full_valid, issue_full, exp_fv, exp_full);
        compare_port("simple", issue_simple_valid, issue_simple, exp_sv, exp_simple);
        if (in_ready !== (ref_q.size() <= `ISSUE_BUF_DEPTH - 2)) begin
            errors++;
            $display("FAIL %0t: in_ready %b with %0d queued", $time, in_ready, ref_q.size());
        end
        if (backend_ready) begin
            lu_valid[0] = exp_fv && slow_result(exp_full);
            lu_valid[1] = exp_sv && slow_result(exp_simple);
            lu_rd[0]    = exp_full.rd;
            lu_rd[1]    = exp_simple.rd;
        end
        repeat (int'(exp_fv) + int'(exp_sv)) void'(ref_q.pop_front());
        if (flush) begin
            ref_q.delete();
            lu_valid = '{1'b0, 1'b0};
        end else if (accept) begin
            ref_q.push_back(in_pair.instr[0]);
            if (in_pair.valid[1]) begin
                ref_q.push_back(in_pair.instr[1]);
            end
        end
        @(negedge clk);
    endtask

    task automatic send(input instr_t a, input instr_t b, input logic two);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_pair  = '{instr: '{b, a}, valid: {two, 1'b1}};
        while (!in_ready && waited < 20) begin
            cycle();
            waited++;
        end
        if (!in_ready) begin
            errors++;
            $display("in_ready stayed low for 20 cycles, a pair could not be sent");
        end
        cycle();
        in_valid = 1'b0;
        in_pair  = '0;
    endtask

    // run until the model queue is empty and then idle once to age the holds
    task automatic expect_drain(input string what, input int want);
        int used;
        used = 0;
        while (ref_q.size() > 0 && used < 20) begin
            cycle();
            used++;
        end
        if (ref_q.size() > 0) begin
            errors++;
            $display("%s: %0d instructions never issued", what, ref_q.size());
            ref_q.delete();
        end else if (want > 0 && used != want) begin
            errors++;
            $display("FAIL %0t: %s took %0d cycles, expected %0d", $time, what, used, want);
        end
        cycle();
    endtask

    task automatic independent_pair();
        send(make_instr(ICLASS_ALU, 5'd1, 5'd2, 5'd3, 1, 0),
             make_instr(ICLASS_ALU, 5'd4, 5'd5, 5'd6, 1, 0), 1);
        expect_drain("independent pair", 1);
    endtask

    task automatic dependent_pair();
        send(make_instr(ICLASS_ALU, 5'd7, 5'd1, 5'd2, 1, 0),
             make_instr(ICLASS_BRANCH, 5'd7, 5'd3, 5'd4, 0, 1), 1);
        expect_drain("younger reads older rd", 2);
        send(make_instr(ICLASS_ALU, 5'd0, 5'd1, 5'd2, 1, 0),
             make_instr(ICLASS_ALU, 5'd3, 5'd0, 5'd0, 1, 0), 1);
        expect_drain("dependence through r0", 1);
        send(make_instr(ICLASS_ALU, 5'd7, 5'd1, 5'd2, 0, 0),
             make_instr(ICLASS_ALU, 5'd3, 5'd7, 5'd7, 1, 0), 1);
        expect_drain("older without reg_write", 1);
    endtask

    task automatic ineligible_younger();
        iclass_e cls[3];
        cls = '{ICLASS_MEM, ICLASS_DIV, ICLASS_PRIV};
        foreach (cls[i]) begin
            send(make_instr(ICLASS_ALU, 5'd1, 5'd2, 5'd3, 1, 0),
                 make_instr(cls[i], 5'd9, 5'd10, 5'd11, 1, 0), 1);
            expect_drain("ineligible younger class", 2);
        end
    endtask

    task automatic load_use_hold();
        send(make_instr(ICLASS_MEM, 5'd5, 5'd1, 5'd2, 1, 0),
             make_instr(ICLASS_ALU, 5'd6, 5'd5, 5'd3, 1, 0), 1);
        expect_drain("load-use on r5", 3);
        // younger stays behind and is the oldest right after the load
        send(make_instr(ICLASS_MEM, 5'd5, 5'd1, 5'd2, 1, 0),
             make_instr(ICLASS_MEM, 5'd6, 5'd7, 5'd3, 1, 0), 1);
        expect_drain("no use of r5", 2);
    endtask

    task automatic backpressure_and_flush();
        backend_ready = 1'b0;
        for (int i = 0; i < N_MIXED; i++) begin
            send(random_instr(), random_instr(), (i % 3) != 2);
            if (i == 1) begin
                if (in_ready !== 1'b0) begin
                    errors++;
                    $display("FAIL %0t: in_ready high with a full buffer", $time);
                end
                repeat (2) cycle();
                backend_ready = 1'b1;
            end
        end
        expect_drain("mixed sequence", 0);
        backend_ready = 1'b0;
        send(make_instr(ICLASS_ALU, 5'd1, 5'd2, 5'd3, 1, 0),
             make_instr(ICLASS_ALU, 5'd4, 5'd5, 5'd6, 1, 0), 1);
        send(make_instr(ICLASS_MUL, 5'd2, 5'd1, 5'd3, 1, 0),
             make_instr(ICLASS_MEM, 5'd4, 5'd2, 5'd6, 1, 0), 1);
        flush = 1'b1;
        cycle();
        flush         = 1'b0;
        backend_ready = 1'b1;
        repeat (4) cycle();
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_pair       = '0;
        backend_ready = 1'b1;
        errors        = 0;
        checks        = 0;
        lcg_state     = 32'hfba2_c763;
        next_pc       = 0;
        lu_valid      = '{1'b0, 1'b0};
        lu_rd         = '{5'd0, 5'd0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        independent_pair();
        dependent_pair();
        ineligible_younger();
        load_use_hold();
        backpressure_and_flush();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // bound on run length of about 20 cycles per pair
    initial begin
        #((NUM_PAIRS * 20 + 200) * 8);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
